//--- common/trellisPkg.sv
// widths and codes follow the external decoder build; only one trellis register is mapped
package trellisPkg;

   // ------------------------------------------------------------------------
   // datapath widths
   // ------------------------------------------------------------------------
   localparam int SampleWidth     = 18;
   localparam int DacWidth        = 18;
   localparam int PhaseErrorWidth = 8;
   localparam int IndexWidth      = 6;
   localparam int DecayWidth      = 8;
   localparam int DacSelectWidth  = 4;

   // register bus
   localparam int AddrWidth = 12;
   localparam int DataWidth = 32;

   // ------------------------------------------------------------------------
   // register map
   // ------------------------------------------------------------------------
   localparam logic [AddrWidth-1:0] TrellisDecayAddr = 12'h400;
   // upper address bits select the trellis block, low nibble the register
   localparam logic [AddrWidth-1:0] TrellisSpaceMask = 12'hFF0;

   localparam logic [DecayWidth-1:0] DecayResetValue = 8'hFF;

   // unlisted monitor DAC codes fall back to phase error
   localparam logic [DacSelectWidth-1:0] DacSelectI          = 4'd0;
   localparam logic [DacSelectWidth-1:0] DacSelectQ          = 4'd1;
   localparam logic [DacSelectWidth-1:0] DacSelectPhaseError = 4'd2;
   localparam logic [DacSelectWidth-1:0] DacSelectIndex      = 4'd3;

   // ------------------------------------------------------------------------
   // bundled signals
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic [SampleWidth-1:0] i;
      logic [SampleWidth-1:0] q;
   } iqSample_t;

   // status coming back from the Viterbi decoder
   typedef struct packed {
      logic                       symEn;
      logic [PhaseErrorWidth-1:0] phaseError;
      logic [IndexWidth-1:0]      index;
      logic [1:0]                 decision;
   } decoderStatus_t;

   typedef struct packed {
      logic                sync;
      logic [DacWidth-1:0] data;
   } dacOut_t;

endpackage

//--- logic/sampleLatch.sv
// sample is taken only on sym2xEn; sampleValid marks the one cycle after each capture
`timescale 1ns/1ps

module sampleLatch (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 sym2xEn,
   input  trellisPkg::iqSample_t sample,
   output trellisPkg::iqSample_t latched,
   output logic                 sampleValid
);

   // hold the I/Q pair between 2x enables
   always_ff @(posedge clk) begin
      if (reset) begin
         latched     <= '0;
         sampleValid <= 1'b0;
      end
      else begin
         // marker lines up with the new latched value
         sampleValid <= sym2xEn;
         if (sym2xEn) begin
            latched <= sample;
         end
      end
   end

endmodule

//--- logic/trellisRegs.sv
// only the decay factor is mapped; writes elsewhere are dropped and reads return zero
`timescale 1ns/1ps

module trellisRegs (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             wr,
   input  logic [trellisPkg::AddrWidth-1:0] addr,
   input  logic [trellisPkg::DataWidth-1:0] din,
   output logic [trellisPkg::DataWidth-1:0] dout,
   output logic [trellisPkg::DecayWidth-1:0] decayFactor
);

   localparam logic [trellisPkg::AddrWidth-1:0] SpaceBase =
      trellisPkg::TrellisDecayAddr & trellisPkg::TrellisSpaceMask;
   localparam logic [trellisPkg::AddrWidth-1:0] DecayOffset =
      trellisPkg::TrellisDecayAddr & ~trellisPkg::TrellisSpaceMask;

   logic                             inSpace;
   logic [trellisPkg::AddrWidth-1:0] regOffset;
   logic                             decaySel;

   // ------------------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------------------
   assign inSpace   = (addr & trellisPkg::TrellisSpaceMask) == SpaceBase;
   assign regOffset = addr & ~trellisPkg::TrellisSpaceMask;
   assign decaySel  = inSpace && (regOffset == DecayOffset);

   // ------------------------------------------------------------------------
   // decay factor register
   // ------------------------------------------------------------------------
   // single-cycle write strobe takes effect on the next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         decayFactor <= trellisPkg::DecayResetValue;
      end
      else if (wr && decaySel) begin
         decayFactor <= din[trellisPkg::DecayWidth-1:0];
      end
   end

   // ------------------------------------------------------------------------
   // readback
   // ------------------------------------------------------------------------
   // combinational readback with no wait states
   always_comb begin
      dout = '0;
      if (decaySel) begin
         dout = {{(trellisPkg::DataWidth-trellisPkg::DecayWidth){1'b0}}, decayFactor};
      end
   end

endmodule

//--- logic/dacChannel.sv
// one monitor channel; I/Q sync follows sampleValid, decoder sources follow decoder.symEn
`timescale 1ns/1ps

module dacChannel (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [trellisPkg::DacSelectWidth-1:0] select,
   input  trellisPkg::iqSample_t                 latched,
   input  logic                                  sampleValid,
   input  trellisPkg::decoderStatus_t            decoder,
   output trellisPkg::dacOut_t                   dac
);

   localparam int PhasePad = trellisPkg::DacWidth - trellisPkg::PhaseErrorWidth;
   localparam int IndexPad = trellisPkg::DacWidth - trellisPkg::IndexWidth - 1;

   logic [trellisPkg::DacWidth-1:0] phaseWord;
   logic [trellisPkg::DacWidth-1:0] indexWord;
   trellisPkg::dacOut_t             nextDac;

   // ------------------------------------------------------------------------
   // scaling to the DAC word
   // ------------------------------------------------------------------------
   // phase error sits in the top bits
   assign phaseWord = {decoder.phaseError, {PhasePad{1'b0}}};
   // index kept positive with a leading zero
   assign indexWord = {1'b0, decoder.index, {IndexPad{1'b0}}};

   // ------------------------------------------------------------------------
   // source select
   // ------------------------------------------------------------------------
   always_comb begin
      case (select)
         trellisPkg::DacSelectI: begin
            nextDac.data = latched.i;
            nextDac.sync = sampleValid;
         end
         trellisPkg::DacSelectQ: begin
            nextDac.data = latched.q;
            nextDac.sync = sampleValid;
         end
         trellisPkg::DacSelectIndex: begin
            nextDac.data = indexWord;
            nextDac.sync = decoder.symEn;
         end
         // phase error code and any unused code
         default: begin
            nextDac.data = phaseWord;
            nextDac.sync = decoder.symEn;
         end
      endcase
   end

   // word and strobe registered together so they stay aligned
   always_ff @(posedge clk) begin
      if (reset) begin
         dac <= '0;
      end
      else begin
         dac <= nextDac;
      end
   end

endmodule

//--- logic/trellisTop.sv
// carrier loop bypassed; matched filters and Viterbi decoder live outside this block
`timescale 1ns/1ps

module trellisTop (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  sym2xEn,
   input  trellisPkg::iqSample_t                 sample,
   input  trellisPkg::decoderStatus_t            decoder,
   // register bus
   input  logic                                  wr,
   input  logic [trellisPkg::AddrWidth-1:0]      addr,
   input  logic [trellisPkg::DataWidth-1:0]      din,
   // monitor selects
   input  logic [trellisPkg::DacSelectWidth-1:0] dac0Select,
   input  logic [trellisPkg::DacSelectWidth-1:0] dac1Select,
   input  logic [trellisPkg::DacSelectWidth-1:0] dac2Select,
   // to the filter bank
   output trellisPkg::iqSample_t                 latched,
   output logic                                  sampleValid,
   // to the decoder
   output logic [trellisPkg::DecayWidth-1:0]     decayFactor,
   output logic [trellisPkg::DataWidth-1:0]      dout,
   output logic [1:0]                            decision,
   // monitor DACs
   output trellisPkg::dacOut_t                   dac0,
   output trellisPkg::dacOut_t                   dac1,
   output trellisPkg::dacOut_t                   dac2
);

   // ------------------------------------------------------------------------
   // sample capture
   // ------------------------------------------------------------------------
   sampleLatch u_sampleLatch (
      .clk         (clk),
      .reset       (reset),
      .sym2xEn     (sym2xEn),
      .sample      (sample),
      .latched     (latched),
      .sampleValid (sampleValid)
   );

   // ------------------------------------------------------------------------
   // register space
   // ------------------------------------------------------------------------
   trellisRegs u_trellisRegs (
      .clk         (clk),
      .reset       (reset),
      .wr          (wr),
      .addr        (addr),
      .din         (din),
      .dout        (dout),
      .decayFactor (decayFactor)
   );

   // decisions go straight on to the line decoder
   assign decision = decoder.decision;

   // ------------------------------------------------------------------------
   // monitor DAC channels
   // ------------------------------------------------------------------------
   dacChannel u_dac0 (
      .clk         (clk),
      .reset       (reset),
      .select      (dac0Select),
      .latched     (latched),
      .sampleValid (sampleValid),
      .decoder     (decoder),
      .dac         (dac0)
   );

   dacChannel u_dac1 (
      .clk         (clk),
      .reset       (reset),
      .select      (dac1Select),
      .latched     (latched),
      .sampleValid (sampleValid),
      .decoder     (decoder),
      .dac         (dac1)
   );

   dacChannel u_dac2 (
      .clk         (clk),
      .reset       (reset),
      .select      (dac2Select),
      .latched     (latched),
      .sampleValid (sampleValid),
      .decoder     (decoder),
      .dac         (dac2)
   );

endmodule

//--- dv/trellisTop_checker.sv
// assertions sample on the rising edge and stay disabled while reset is high
`timescale 1ns/1ps

module trellisTop_checker (
   input logic                             clk,
   input logic                             reset,
   input logic                             sampleValid,
   input trellisPkg::decoderStatus_t       decoder,
   input logic [trellisPkg::AddrWidth-1:0] addr,
   input logic [trellisPkg::DataWidth-1:0] dout,
   input trellisPkg::dacOut_t              dac0,
   input trellisPkg::dacOut_t              dac1,
   input trellisPkg::dacOut_t              dac2
);

   logic syncSource;

   // any strobe that a DAC sync can follow
   assign syncSource = sampleValid || decoder.symEn;

   // ------------------------------------------------------------------------
   // DAC sync follows a source strobe by one cycle
   // ------------------------------------------------------------------------
   dac0SyncSource: assert property (@(posedge clk) disable iff (reset)
      dac0.sync |-> $past(syncSource)) else $error("dac0 sync without a source strobe");
   dac1SyncSource: assert property (@(posedge clk) disable iff (reset)
      dac1.sync |-> $past(syncSource)) else $error("dac1 sync without a source strobe");
   dac2SyncSource: assert property (@(posedge clk) disable iff (reset)
      dac2.sync |-> $past(syncSource)) else $error("dac2 sync without a source strobe");

   // one-cycle sample marker
   validPulse: assert property (@(posedge clk) disable iff (reset)
      sampleValid |=> !sampleValid) else $error("sampleValid held for two cycles");

   // unmapped reads give zero
   unmappedRead: assert property (@(posedge clk) disable iff (reset)
      (addr != trellisPkg::TrellisDecayAddr) |-> (dout == '0))
      else $error("nonzero readback outside the decay register");

endmodule

bind trellisTop trellisTop_checker u_checker (
   .clk         (clk),
   .reset       (reset),
   .sampleValid (sampleValid),
   .decoder     (decoder),
   .addr        (addr),
   .dout        (dout),
   .dac0        (dac0),
   .dac1        (dac1),
   .dac2        (dac2)
);

//--- dv/trellisTb.sv
// inputs change on the rising edge and outputs are sampled on the falling edge; seed 97
`timescale 1ns/1ps

module trellisTb;

   logic                                  clk;
   logic                                  reset;
   logic                                  sym2xEn;
   trellisPkg::iqSample_t                 sample;
   trellisPkg::decoderStatus_t            decoder;
   logic                                  wr;
   logic [trellisPkg::AddrWidth-1:0]      addr;
   logic [trellisPkg::DataWidth-1:0]      din;
   logic [trellisPkg::DacSelectWidth-1:0] dac0Select;
   logic [trellisPkg::DacSelectWidth-1:0] dac1Select;
   logic [trellisPkg::DacSelectWidth-1:0] dac2Select;
   trellisPkg::iqSample_t                 latched;
   logic                                  sampleValid;
   logic [trellisPkg::DecayWidth-1:0]     decayFactor;
   logic [trellisPkg::DataWidth-1:0]      dout;
   logic [1:0]                            decision;
   trellisPkg::dacOut_t                   dac0;
   trellisPkg::dacOut_t                   dac1;
   trellisPkg::dacOut_t                   dac2;

   trellisTop u_dut (
      .clk         (clk),
      .reset       (reset),
      .sym2xEn     (sym2xEn),
      .sample      (sample),
      .decoder     (decoder),
      .wr          (wr),
      .addr        (addr),
      .din         (din),
      .dac0Select  (dac0Select),
      .dac1Select  (dac1Select),
      .dac2Select  (dac2Select),
      .latched     (latched),
      .sampleValid (sampleValid),
      .decayFactor (decayFactor),
      .dout        (dout),
      .decision    (decision),
      .dac0        (dac0),
      .dac1        (dac1),
      .dac2        (dac2)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // reporting and bus helpers
   // ------------------------------------------------------------------------
   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic expectEqual(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         abortRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
      end
   endtask

   task automatic writeReg(input logic [11:0] a, input logic [31:0] d);
      @(posedge clk);
      wr   <= 1'b1;
      addr <= a;
      din  <= d;
      @(posedge clk);
      wr   <= 1'b0;
   endtask

   task automatic readReg(input logic [11:0] a, output logic [31:0] data);
      @(posedge clk);
      wr   <= 1'b0;
      addr <= a;
      @(negedge clk);
      data = dout;
   endtask

   function automatic logic syncOf(input int chan);
      case (chan)
         0: return dac0.sync;
         1: return dac1.sync;
         default: return dac2.sync;
      endcase
   endfunction

   // counts falling edges until the channel's sync rises
   task automatic waitDacSync(input int chan, input int limit, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!syncOf(chan) && cycles < limit);
      if (!syncOf(chan)) begin
         abortRun($sformatf("DAC channel %0d sync did not rise within %0d cycles", chan, limit));
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic resetStateTest();
      logic [31:0] readData;
      @(negedge clk);
      expectEqual("dac0", 64'(dac0), 64'h0);
      expectEqual("dac1", 64'(dac1), 64'h0);
      expectEqual("dac2", 64'(dac2), 64'h0);
      expectEqual("sampleValid", 64'(sampleValid), 64'h0);
      expectEqual("latched", 64'(latched), 64'h0);
      readReg(12'h400, readData);
      expectEqual("dout", 64'(readData), 64'hFF);
   endtask

   task automatic decayRegisterTest();
      logic [7:0]  value;
      logic [31:0] readData;
      value = 8'($urandom);
      // upper data bits are not stored
      writeReg(12'h400, {24'($urandom), value});
      @(negedge clk);
      expectEqual("decayFactor", 64'(decayFactor), 64'(value));
      expectEqual("dout", 64'(dout), 64'(value));
      writeReg(12'h404, {24'h0, ~value});
      @(negedge clk);
      expectEqual("decayFactor", 64'(decayFactor), 64'(value));
      readReg(12'h404, readData);
      expectEqual("dout", 64'(readData), 64'h0);
      readReg(12'h123, readData);
      expectEqual("dout", 64'(readData), 64'h0);
   endtask

   task automatic iqMonitorTest();
      logic [17:0] iVal;
      logic [17:0] qVal;
      int          cycles;
      iVal = 18'($urandom);
      qVal = 18'($urandom);
      @(posedge clk);
      dac0Select <= trellisPkg::DacSelectI;
      dac1Select <= trellisPkg::DacSelectQ;
      dac2Select <= trellisPkg::DacSelectPhaseError;
      sym2xEn    <= 1'b1;
      sample     <= {iVal, qVal};
      @(posedge clk);
      sym2xEn    <= 1'b0;
      @(negedge clk);
      // new pair and its marker arrive together
      expectEqual("sampleValid", 64'(sampleValid), 64'h1);
      expectEqual("latched", 64'(latched), 64'({iVal, qVal}));
      waitDacSync(0, 4, cycles);
      expectEqual("dac0 sync latency", 64'(cycles), 64'd1);
      expectEqual("sampleValid", 64'(sampleValid), 64'h0);
      expectEqual("latched", 64'(latched), 64'({iVal, qVal}));
      expectEqual("dac0 data", 64'(dac0.data), 64'(iVal));
      expectEqual("dac1 data", 64'(dac1.data), 64'(qVal));
      expectEqual("dac1 sync", 64'(dac1.sync), 64'h1);
      expectEqual("dac2 sync", 64'(dac2.sync), 64'h0);
      @(negedge clk);
      expectEqual("dac0 sync", 64'(dac0.sync), 64'h0);
      expectEqual("dac1 sync", 64'(dac1.sync), 64'h0);
   endtask

   task automatic decoderMonitorTest();
      logic [7:0] pe;
      logic [5:0] idx;
      logic [1:0] dec;
      int         cycles;
      pe  = 8'($urandom);
      idx = 6'($urandom);
      dec = 2'($urandom);
      @(posedge clk);
      dac0Select <= trellisPkg::DacSelectPhaseError;
      dac1Select <= trellisPkg::DacSelectPhaseError;
      dac2Select <= trellisPkg::DacSelectIndex;
      decoder    <= {1'b1, pe, idx, dec};
      @(posedge clk);
      decoder.symEn <= 1'b0;
      waitDacSync(2, 4, cycles);
      expectEqual("dac2 sync latency", 64'(cycles), 64'd1);
      // phase error in the top byte, index behind one zero bit
      expectEqual("dac0 data", 64'(dac0.data), 64'({pe, 10'h000}));
      expectEqual("dac1 data", 64'(dac1.data), 64'({pe, 10'h000}));
      expectEqual("dac2 data", 64'(dac2.data), 64'({1'b0, idx, 11'h000}));
      expectEqual("dac0 sync", 64'(dac0.sync), 64'h1);
      expectEqual("dac1 sync", 64'(dac1.sync), 64'h1);
   endtask

   task automatic unusedSelectTest();
      logic [7:0]  pe;
      logic [17:0] iVal;
      int          cycles;
      pe   = 8'($urandom);
      iVal = 18'($urandom);
      @(posedge clk);
      dac0Select <= 4'hA;
      dac1Select <= trellisPkg::DacSelectPhaseError;
      dac2Select <= trellisPkg::DacSelectI;
      decoder    <= {1'b1, pe, 6'($urandom), 2'($urandom)};
      @(posedge clk);
      decoder.symEn <= 1'b0;
      waitDacSync(0, 4, cycles);
      expectEqual("dac0 sync latency", 64'(cycles), 64'd1);
      expectEqual("dac0", 64'(dac0), 64'({1'b1, pe, 10'h000}));
      expectEqual("dac1", 64'(dac1), 64'({1'b1, pe, 10'h000}));
      expectEqual("dac2 sync", 64'(dac2.sync), 64'h0);
      // sample strobe only reaches the I channel
      @(posedge clk);
      sym2xEn <= 1'b1;
      sample  <= {iVal, 18'($urandom)};
      @(posedge clk);
      sym2xEn <= 1'b0;
      waitDacSync(2, 5, cycles);
      expectEqual("dac2 sync latency", 64'(cycles), 64'd2);
      expectEqual("dac2 data", 64'(dac2.data), 64'(iVal));
      expectEqual("dac0 sync", 64'(dac0.sync), 64'h0);
      expectEqual("dac1 sync", 64'(dac1.sync), 64'h0);
   endtask

   task automatic decisionPassTest();
      logic [1:0] dec;
      repeat (4) begin
         dec = 2'($urandom);
         @(posedge clk);
         decoder.decision <= dec;
         @(negedge clk);
         expectEqual("decision", 64'(decision), 64'(dec));
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin
      void'($urandom(97));
      reset      <= 1'b1;
      sym2xEn    <= 1'b0;
      sample     <= '0;
      decoder    <= '0;
      wr         <= 1'b0;
      addr       <= '0;
      din        <= '0;
      dac0Select <= trellisPkg::DacSelectI;
      dac1Select <= trellisPkg::DacSelectQ;
      dac2Select <= trellisPkg::DacSelectPhaseError;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      resetStateTest();
      decayRegisterTest();
      iqMonitorTest();
      decoderMonitorTest();
      unusedSelectTest();
      decisionPassTest();
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- sim.f
common/trellisPkg.sv
logic/sampleLatch.sv
logic/trellisRegs.sv
logic/dacChannel.sv
logic/trellisTop.sv
dv/trellisTop_checker.sv
dv/trellisTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module trellisTb -f sim.f -o trellisSim

# the simulator status is not used; the log decides
./obj_dir/trellisSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
